/* hw/kb_pkg.sv */
package kb_pkg;

  // one byte as it comes from the keyboard
  typedef logic [7:0] scancode_t;

  // APB byte address and data word
  typedef logic [11:0] apb_addr_t;
  typedef logic [31:0] apb_data_t;

  // one bit per non-prefix scancode, index = code[6:0]
  typedef logic [127:0] key_map_t;

  // a received byte, valid pulses for a single clock
  typedef struct packed {
    logic      valid;
    scancode_t code;
  } kb_event_t;

  // buffer fill state as seen by software
  typedef struct packed {
    logic       available;
    logic       overflow;
    logic [7:0] count;
  } buf_status_t;

  // register map, buffer entries live below these
  localparam apb_addr_t ADDR_CTRL = 12'h200;
  localparam apb_addr_t ADDR_ERR  = 12'h204;
  // four consecutive words, 0x210 .. 0x21c
  localparam apb_addr_t ADDR_MAP0 = 12'h210;
  localparam apb_addr_t ADDR_HELD = 12'h220;

  // set 2 prefixes
  localparam scancode_t CODE_BREAK = 8'hF0;
  localparam scancode_t CODE_EXT   = 8'hE0;

endpackage

/* hw/ps2_rx.sv */
`timescale 1ns/1ps

module ps2_rx (
  input  logic              clk_in,
  input  logic              rst_in,
  input  logic              ps2_clk,
  input  logic              ps2_data,
  output kb_pkg::kb_event_t kb_event,
  output logic              parity_err,
  output logic              frame_err
);

  import kb_pkg::*;

  // frame is start, 8 data bits LSB first, odd parity, stop
  typedef enum logic [1:0] {
    ST_IDLE,
    ST_DATA,
    ST_PARITY,
    ST_STOP
  } rx_state_t;

  // two-stage synchronizers for both pins
  logic [1:0] clk_sync;
  logic [1:0] data_sync;
  // previous synchronized clock level, for edge detect
  logic       clk_prev;
  logic       fall;
  logic       bit_in;

  rx_state_t  state;
  logic [2:0] bit_cnt;
  scancode_t  shift;
  logic       parity_bit;
  logic       parity_ok;

  // lines idle high, so reset the sync chain to 1
  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      clk_sync  <= 2'b11;
      data_sync <= 2'b11;
      clk_prev  <= 1'b1;
    end else begin
      clk_sync  <= {clk_sync[0], ps2_clk};
      data_sync <= {data_sync[0], ps2_data};
      clk_prev  <= clk_sync[1];
    end
  end

  // keyboard changes data on rising edge, we sample on falling
  assign fall   = clk_prev & ~clk_sync[1];
  assign bit_in = data_sync[1];

  // data bits plus parity must hold an odd number of ones
  assign parity_ok = ^{shift, parity_bit};

  // deserializer datapath
  always_ff @(posedge clk_in) begin
    if (fall && state == ST_DATA) begin
      shift <= {bit_in, shift[7:1]};
    end
    if (fall && state == ST_PARITY) begin
      parity_bit <= bit_in;
    end
  end

  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      state      <= ST_IDLE;
      bit_cnt    <= '0;
      kb_event   <= '0;
      parity_err <= 1'b0;
      frame_err  <= 1'b0;
    end else begin
      // event and error outputs are single-cycle pulses
      kb_event.valid <= 1'b0;
      parity_err     <= 1'b0;
      frame_err      <= 1'b0;
      if (fall) begin
        case (state)
          ST_IDLE: begin
            // a high start bit is noise, stay idle
            if (!bit_in) begin
              state   <= ST_DATA;
              bit_cnt <= '0;
            end
          end
          ST_DATA: begin
            bit_cnt <= bit_cnt + 3'd1;
            if (bit_cnt == 3'd7) begin
              state <= ST_PARITY;
            end
          end
          ST_PARITY: begin
            state <= ST_STOP;
          end
          ST_STOP: begin
            state <= ST_IDLE;
            // a missing stop bit takes precedence over bad parity
            if (!bit_in) begin
              frame_err <= 1'b1;
            end else if (!parity_ok) begin
              parity_err <= 1'b1;
            end else begin
              kb_event.valid <= 1'b1;
              kb_event.code  <= shift;
            end
          end
          default: state <= ST_IDLE;
        endcase
      end
    end
  end

endmodule

/* hw/scancode_buffer.sv */
`timescale 1ns/1ps

module scancode_buffer #(
  parameter int BUF_DEPTH_LOG2 = 7
) (
  input  logic                      clk_in,
  input  logic                      rst_in,
  input  kb_pkg::kb_event_t         kb_event,
  input  logic                      clear,
  input  logic [BUF_DEPTH_LOG2-1:0] rd_index,
  output kb_pkg::scancode_t         rd_data,
  output kb_pkg::buf_status_t       status
);

  import kb_pkg::*;

  localparam int DEPTH = 1 << BUF_DEPTH_LOG2;

  // byte RAM, filled from entry 0 in arrival order
  scancode_t mem [DEPTH];

  // one extra bit so a full buffer is representable
  logic [BUF_DEPTH_LOG2:0]   count;
  logic                      overflow;
  logic                      full;
  logic                      wr_en;
  // registered read address for the synchronous port
  logic [BUF_DEPTH_LOG2-1:0] rd_addr_q;

  // count never passes DEPTH, so the top bit alone marks full
  assign full = count[BUF_DEPTH_LOG2];

  // clear beats a simultaneous event
  // a full buffer drops the byte but the receiver keeps going
  assign wr_en = kb_event.valid & ~clear & ~full;

  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      count    <= '0;
      overflow <= 1'b0;
    end else if (clear) begin
      count    <= '0;
      overflow <= 1'b0;
    end else if (kb_event.valid) begin
      if (full) begin
        // stays set until software clears the buffer
        overflow <= 1'b1;
      end else begin
        count <= count + 1'b1;
      end
    end
  end

  // write port, next free slot is the current count
  always_ff @(posedge clk_in) begin
    if (wr_en) begin
      mem[count[BUF_DEPTH_LOG2-1:0]] <= kb_event.code;
    end
  end

  // read port
  // address registered, then data registered
  // data shows up on the second clock after rd_index
  always_ff @(posedge clk_in) begin
    rd_addr_q <= rd_index;
    rd_data   <= mem[rd_addr_q];
  end

  // status for the register block
  assign status.available = (count != '0);
  assign status.overflow  = overflow;
  assign status.count     = 8'(count);

endmodule

/* hw/key_state_tracker.sv */
`timescale 1ns/1ps

module key_state_tracker (
  input  logic              clk_in,
  input  logic              rst_in,
  input  kb_pkg::kb_event_t kb_event,
  output kb_pkg::key_map_t  key_map,
  output logic [7:0]        held_count
);

  import kb_pkg::*;

  // an F0 was seen, next key code is a release
  logic       break_pending;
  logic [6:0] key_idx;
  // current state of the addressed key
  logic       key_down;

  assign key_idx  = kb_event.code[6:0];
  assign key_down = key_map[key_idx];

  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      break_pending <= 1'b0;
      key_map       <= '0;
      held_count    <= '0;
    end else if (kb_event.valid) begin
      if (kb_event.code == CODE_BREAK) begin
        break_pending <= 1'b1;
      end else if (kb_event.code != CODE_EXT) begin
        // E0 is skipped and leaves a pending break intact
        // so E0 F0 xx releases the base key xx
        break_pending <= 1'b0;
        // codes 80..FF carry no key bit
        if (!kb_event.code[7]) begin
          if (break_pending) begin
            key_map[key_idx] <= 1'b0;
            // release of a key not held leaves the count alone
            if (key_down) begin
              held_count <= held_count - 8'd1;
            end
          end else begin
            key_map[key_idx] <= 1'b1;
            // typematic repeats of a held key do not count twice
            if (!key_down) begin
              held_count <= held_count + 8'd1;
            end
          end
        end
      end
    end
  end

endmodule

/* hw/kb_apb_regs.sv */
`timescale 1ns/1ps

module kb_apb_regs #(
  parameter int BUF_DEPTH_LOG2 = 7
) (
  input  logic                      clk_in,
  input  logic                      rst_in,
  input  logic                      psel,
  input  logic                      penable,
  input  logic                      pwrite,
  input  kb_pkg::apb_addr_t         paddr,
  input  kb_pkg::apb_data_t         pwdata,
  output kb_pkg::apb_data_t         prdata,
  output logic                      pready,
  output logic                      pslverr,
  output logic [BUF_DEPTH_LOG2-1:0] rd_index,
  input  kb_pkg::scancode_t         rd_data,
  input  kb_pkg::buf_status_t       status,
  input  logic                      parity_err,
  input  logic                      frame_err,
  input  kb_pkg::key_map_t          key_map,
  input  logic [7:0]                held_count,
  output logic                      clear,
  output logic                      irq
);

  import kb_pkg::*;

  // target of the current transfer, latched in the setup phase
  typedef struct packed {
    logic       buf_hit;
    logic       ctrl;
    logic       err;
    logic       map;
    logic       held;
    logic [1:0] word;
  } apb_sel_t;

  apb_sel_t  sel_d;
  apb_sel_t  sel_q;
  logic      setup;
  logic      access;
  logic      mapped;
  logic      buf_wait;
  logic      wr_done;
  logic      parity_flag;
  logic      frame_flag;
  apb_data_t rd_word;

  assign setup  = psel & ~penable;
  assign access = psel & penable;

  always_comb begin
    sel_d         = '0;
    // buffer entries occupy 0 .. 4*depth-4
    sel_d.buf_hit = (paddr[11:BUF_DEPTH_LOG2+2] == '0);
    sel_d.ctrl    = (paddr == ADDR_CTRL);
    sel_d.err     = (paddr == ADDR_ERR);
    sel_d.map     = (paddr[11:4] == ADDR_MAP0[11:4]);
    sel_d.held    = (paddr == ADDR_HELD);
    sel_d.word    = paddr[3:2];
  end

  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      sel_q <= '0;
    end else if (setup) begin
      sel_q <= sel_d;
    end
  end

  assign mapped = sel_q.buf_hit | sel_q.ctrl | sel_q.err | sel_q.map | sel_q.held;

  // RAM sees the index already in setup, paddr is stable through access
  assign rd_index = paddr[BUF_DEPTH_LOG2+1:2];

  // buffer reads stall one cycle for the registered RAM output
  assign pready = access & (~sel_q.buf_hit | pwrite | buf_wait);

  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      buf_wait <= 1'b0;
    end else begin
      buf_wait <= access & ~pready;
    end
  end

  // unmapped space answers with an error, data stays zero
  assign pslverr = pready & ~mapped;
  assign wr_done = pready & pwrite;

  // write data is don't-care, any write to CTRL or ERR acts as a clear
  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      clear       <= 1'b0;
      parity_flag <= 1'b0;
      frame_flag  <= 1'b0;
    end else begin
      clear <= wr_done & sel_q.ctrl;
      // a new error in the clearing cycle is kept
      parity_flag <= (parity_flag & ~(wr_done & sel_q.err)) | parity_err;
      frame_flag  <= (frame_flag & ~(wr_done & sel_q.err)) | frame_err;
    end
  end

  // read mux
  always_comb begin
    rd_word = '0;
    if (sel_q.buf_hit) begin
      rd_word = {24'd0, rd_data};
    end else if (sel_q.ctrl) begin
      rd_word = {16'd0, status.count, 6'd0, status.overflow, status.available};
    end else if (sel_q.err) begin
      rd_word = {30'd0, frame_flag, parity_flag};
    end else if (sel_q.map) begin
      // word k holds keys 32k .. 32k+31
      rd_word = key_map[{sel_q.word, 5'd0} +: 32];
    end else if (sel_q.held) begin
      rd_word = {24'd0, held_count};
    end
  end

  assign prdata = (pready & ~pwrite) ? rd_word : '0;

  // level interrupt, drops when software clears the buffer
  assign irq = status.available;

endmodule

/* hw/kb_subsystem.sv */
`timescale 1ns/1ps

module kb_subsystem #(
  parameter int BUF_DEPTH_LOG2 = 7
) (
  input  logic              clk_in,
  input  logic              rst_in,
  input  logic              psel,
  input  logic              penable,
  input  logic              pwrite,
  input  kb_pkg::apb_addr_t paddr,
  input  kb_pkg::apb_data_t pwdata,
  output kb_pkg::apb_data_t prdata,
  output logic              pready,
  output logic              pslverr,
  input  logic              ps2_clk,
  input  logic              ps2_data,
  output logic              irq
);

  import kb_pkg::*;

  // receiver fans out to buffer and tracker
  kb_event_t                 kb_event;
  logic                      parity_err;
  logic                      frame_err;
  // buffer side of the register block
  logic [BUF_DEPTH_LOG2-1:0] rd_index;
  scancode_t                 rd_data;
  buf_status_t               status;
  logic                      clear;
  // tracker results
  key_map_t                  key_map;
  logic [7:0]                held_count;

  ps2_rx i_ps2_rx (
    .clk_in     (clk_in),
    .rst_in     (rst_in),
    .ps2_clk    (ps2_clk),
    .ps2_data   (ps2_data),
    .kb_event   (kb_event),
    .parity_err (parity_err),
    .frame_err  (frame_err)
  );

  scancode_buffer #(
    .BUF_DEPTH_LOG2 (BUF_DEPTH_LOG2)
  ) i_scancode_buffer (
    .clk_in   (clk_in),
    .rst_in   (rst_in),
    .kb_event (kb_event),
    .clear    (clear),
    .rd_index (rd_index),
    .rd_data  (rd_data),
    .status   (status)
  );

  key_state_tracker i_key_state_tracker (
    .clk_in     (clk_in),
    .rst_in     (rst_in),
    .kb_event   (kb_event),
    .key_map    (key_map),
    .held_count (held_count)
  );

  kb_apb_regs #(
    .BUF_DEPTH_LOG2 (BUF_DEPTH_LOG2)
  ) i_kb_apb_regs (
    .clk_in     (clk_in),
    .rst_in     (rst_in),
    .psel       (psel),
    .penable    (penable),
    .pwrite     (pwrite),
    .paddr      (paddr),
    .pwdata     (pwdata),
    .prdata     (prdata),
    .pready     (pready),
    .pslverr    (pslverr),
    .rd_index   (rd_index),
    .rd_data    (rd_data),
    .status     (status),
    .parity_err (parity_err),
    .frame_err  (frame_err),
    .key_map    (key_map),
    .held_count (held_count),
    .clear      (clear),
    .irq        (irq)
  );

endmodule

/* testbench/tb_kb_subsystem.sv */
`timescale 1ns/1ps

module tb_kb_subsystem;

  import kb_pkg::*;

  localparam int BUF_DEPTH_LOG2 = 7;
  localparam int DEPTH          = 1 << BUF_DEPTH_LOG2;
  // ps2 bit period in system clocks
  localparam int BIT_CYCLES     = 16;
  // upper bounds on the traffic of all tests
  localparam int MAX_FRAMES     = 240;
  localparam int APB_XFERS      = 256;
  // each transfer is setup, up to two access cycles, release and a gap of up to 3
  localparam int LIMIT = (MAX_FRAMES * 11 * BIT_CYCLES + APB_XFERS * 8) * 2;

  logic      clk_in;
  logic      rst_in;
  logic      psel;
  logic      penable;
  logic      pwrite;
  apb_addr_t paddr;
  apb_data_t pwdata;
  apb_data_t prdata;
  logic      pready;
  logic      pslverr;
  logic      ps2_clk;
  logic      ps2_data;
  logic      irq;

  logic [31:0] seed = 32'h4eb3_816d;
  int          cycles = 0;

  // reference model state
  scancode_t  stored[$];
  logic       model_overflow;
  logic       model_perr;
  key_map_t   model_map;
  logic [7:0] model_held;
  // break prefix seen and its key still to come
  logic       model_brk;

  kb_subsystem #(
    .BUF_DEPTH_LOG2 (BUF_DEPTH_LOG2)
  ) i_kb_subsystem (
    .clk_in   (clk_in),
    .rst_in   (rst_in),
    .psel     (psel),
    .penable  (penable),
    .pwrite   (pwrite),
    .paddr    (paddr),
    .pwdata   (pwdata),
    .prdata   (prdata),
    .pready   (pready),
    .pslverr  (pslverr),
    .ps2_clk  (ps2_clk),
    .ps2_data (ps2_data),
    .irq      (irq)
  );

  always #5 clk_in = ~clk_in;

  // watchdog
  always @(posedge clk_in) begin
    cycles <= cycles + 1;
    if (cycles >= LIMIT) begin
      $display("timeout: tests did not finish within %0d clock cycles", LIMIT);
      $display("FAIL: see errors above");
      $fatal(1, "stopped by watchdog");
    end
  end

  function automatic logic [31:0] next_random();
    seed = seed * 32'd1664525 + 32'd1013904223;
    return seed;
  endfunction

  task automatic check_code(input string name, input scancode_t got, input scancode_t exp);
    if (got !== exp) begin
      $display("CHECK FAILED at %0t: %s got %h expected %h", $time, name, got, exp);
      $display("FAIL: see errors above");
      $fatal(1, "scancode mismatch");
    end
  endtask

  task automatic check_status(input string name, input buf_status_t got,
                              input buf_status_t exp);
    if (got !== exp) begin
      $display("CHECK FAILED at %0t: %s got %h expected %h", $time, name, got, exp);
      $display("FAIL: see errors above");
      $fatal(1, "status mismatch");
    end
  endtask

  task automatic check_word(input string name, input apb_data_t got, input apb_data_t exp);
    if (got !== exp) begin
      $display("CHECK FAILED at %0t: %s got %h expected %h", $time, name, got, exp);
      $display("FAIL: see errors above");
      $fatal(1, "data word mismatch");
    end
  endtask

  task automatic check_map(input string name, input key_map_t got, input key_map_t exp);
    if (got !== exp) begin
      $display("CHECK FAILED at %0t: %s got %h expected %h", $time, name, got, exp);
      $display("FAIL: see errors above");
      $fatal(1, "key map mismatch");
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("CHECK FAILED at %0t: %s got %b expected %b", $time, name, got, exp);
      $display("FAIL: see errors above");
      $fatal(1, "flag mismatch");
    end
  endtask

  // what the buffer and tracker should do with one frame
  task automatic model_receive(input scancode_t code, input logic bad_parity);
    if (bad_parity) begin
      model_perr = 1'b1;
    end else begin
      if (stored.size() < DEPTH) begin
        stored.push_back(code);
      end else begin
        model_overflow = 1'b1;
      end
      if (code == CODE_BREAK) begin
        model_brk = 1'b1;
      end else if (code != CODE_EXT) begin
        // codes 80..FF hold no key
        if (code < 8'h80) begin
          if (model_brk && model_map[code[6:0]]) begin
            model_held = model_held - 8'd1;
          end else if (!model_brk && !model_map[code[6:0]]) begin
            model_held = model_held + 8'd1;
          end
          model_map[code[6:0]] = ~model_brk;
        end
        model_brk = 1'b0;
      end
    end
  endtask

  // start, 8 data bits LSB first, odd parity, stop
  task automatic send_frame(input scancode_t code, input logic bad_parity);
    logic [10:0] bits;
    bits = {1'b1, (~^code) ^ bad_parity, code, 1'b0};
    for (int i = 0; i < 11; i++) begin
      // data changes while ps2_clk is high
      @(negedge clk_in);
      ps2_data = bits[i];
      repeat (BIT_CYCLES / 2 - 1) @(negedge clk_in);
      ps2_clk = 1'b0;
      repeat (BIT_CYCLES / 2) @(negedge clk_in);
      ps2_clk = 1'b1;
    end
    // idle gap that outlasts the 4-cycle path from stop bit to status
    repeat (4) @(negedge clk_in);
    model_receive(code, bad_parity);
  endtask

  task automatic apb_access(input logic wr, input apb_addr_t addr, input apb_data_t wdata,
                            input logic exp_err, output apb_data_t rdata);
    logic [31:0] r;
    @(negedge clk_in);
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = wr;
    paddr   = addr;
    pwdata  = wdata;
    @(negedge clk_in);
    penable = 1'b1;
    // sample away from the clock edge
    #1;
    while (!pready) begin
      @(negedge clk_in);
      #1;
    end
    rdata = prdata;
    check_flag("pslverr", pslverr, exp_err);
    @(negedge clk_in);
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
    r = next_random();
    repeat (r[17:16]) @(negedge clk_in);
  endtask

  task automatic apb_write(input apb_addr_t addr, input apb_data_t data);
    apb_data_t unused;
    apb_access(1'b1, addr, data, 1'b0, unused);
  endtask

  task automatic apb_read(input apb_addr_t addr, input logic exp_err, output apb_data_t data);
    apb_access(1'b0, addr, '0, exp_err, data);
  endtask

  task automatic clear_buffer();
    apb_write(ADDR_CTRL, next_random());
    stored.delete();
    model_overflow = 1'b0;
  endtask

  task automatic verify_status();
    apb_data_t   w;
    buf_status_t got;
    buf_status_t exp;
    apb_read(ADDR_CTRL, 1'b0, w);
    got.available = w[0];
    got.overflow  = w[1];
    got.count     = w[15:8];
    exp.available = (stored.size() != 0);
    exp.overflow  = model_overflow;
    exp.count     = 8'(stored.size());
    check_status("ctrl status", got, exp);
    // bits outside the status fields read zero
    check_word("ctrl unused bits", w & 32'hFFFF_00FC, '0);
    check_flag("irq", irq, exp.available);
  endtask

  task automatic verify_entries();
    apb_data_t w;
    for (int i = 0; i < stored.size(); i++) begin
      apb_read(apb_addr_t'(4 * i), 1'b0, w);
      check_code("buffer entry", w[7:0], stored[i]);
      check_word("buffer entry upper bits", w & 32'hFFFF_FF00, '0);
    end
  endtask

  task automatic verify_errors();
    apb_data_t w;
    apb_read(ADDR_ERR, 1'b0, w);
    check_word("error flags", w, {30'd0, 1'b0, model_perr});
  endtask

  task automatic verify_keys();
    apb_data_t w;
    key_map_t  got;
    for (int k = 0; k < 4; k++) begin
      apb_read(apb_addr_t'(ADDR_MAP0 + 4 * k), 1'b0, w);
      got[32 * k +: 32] = w;
    end
    check_map("key map", got, model_map);
    apb_read(ADDR_HELD, 1'b0, w);
    check_word("held count", w, {24'd0, model_held});
  endtask

  initial begin
    logic [31:0] r;
    logic        bad;
    scancode_t   key;
    apb_data_t   w;
    clk_in         = 1'b0;
    rst_in         = 1'b1;
    psel           = 1'b0;
    penable        = 1'b0;
    pwrite         = 1'b0;
    paddr          = '0;
    pwdata         = '0;
    ps2_clk        = 1'b1;
    ps2_data       = 1'b1;
    model_overflow = 1'b0;
    model_perr     = 1'b0;
    model_map      = '0;
    model_held     = '0;
    model_brk      = 1'b0;
    repeat (3) @(negedge clk_in);
    rst_in = 1'b0;
    check_flag("irq", irq, 1'b0);
    verify_status();
    verify_errors();

    // random bytes come back in arrival order
    repeat (24) send_frame(scancode_t'(next_random() >> 16), 1'b0);
    verify_status();
    verify_entries();
    verify_keys();

    // clear empties the buffer and refill starts at entry 0
    clear_buffer();
    verify_status();
    repeat (10) send_frame(scancode_t'(next_random() >> 16), 1'b0);
    verify_status();
    verify_entries();

    // two codes past full are dropped and flag overflow
    clear_buffer();
    repeat (DEPTH + 2) send_frame(scancode_t'(next_random() >> 16), 1'b0);
    verify_status();
    verify_entries();
    verify_keys();
    clear_buffer();
    verify_status();

    // parity errors where the last frame is forced bad if no earlier one was
    for (int i = 0; i < 4; i++) begin
      r   = next_random();
      bad = r[20] | (i == 3 && !model_perr);
      send_frame(scancode_t'(r >> 8), bad);
    end
    verify_errors();
    verify_status();
    verify_entries();
    apb_write(ADDR_ERR, next_random());
    model_perr = 1'b0;
    verify_errors();

    // press and release with break and extended prefixes
    for (int i = 0; i < 20; i++) begin
      r   = next_random();
      // small key pool so presses and releases meet
      key = {3'b000, r[12:8]} + 8'h10;
      case (r[17:16])
        2'd0: send_frame(key, 1'b0);
        2'd1: begin
          send_frame(CODE_BREAK, 1'b0);
          send_frame(key, 1'b0);
        end
        2'd2: begin
          send_frame(CODE_EXT, 1'b0);
          send_frame(key, 1'b0);
        end
        default: begin
          send_frame(CODE_EXT, 1'b0);
          send_frame(CODE_BREAK, 1'b0);
          send_frame(key, 1'b0);
        end
      endcase
    end
    verify_keys();
    verify_status();

    // holes in the map read zero with an error response
    apb_read(12'h208, 1'b1, w);
    check_word("unmapped 208", w, '0);
    apb_read(12'h224, 1'b1, w);
    check_word("unmapped 224", w, '0);
    apb_read(12'h300, 1'b1, w);
    check_word("unmapped 300", w, '0);
    apb_read(12'hFFC, 1'b1, w);
    check_word("unmapped ffc", w, '0);

    $display("PASS: all tests");
    $finish;
  end

endmodule

/* all.f */
hw/kb_pkg.sv
hw/ps2_rx.sv
hw/scancode_buffer.sv
hw/key_state_tracker.sv
hw/kb_apb_regs.sv
hw/kb_subsystem.sv
testbench/tb_kb_subsystem.sv

/* run_sim.sh */
#!/bin/sh
rm -rf obj_dir sim.log build.log
verilator --binary --timing --timescale 1ns/1ps --top-module tb_kb_subsystem \
  -f all.f -o sim_kb > build.log 2>&1 \
  || { cat build.log; echo "build failed"; exit 1; }
./obj_dir/sim_kb > sim.log 2>&1
cat sim.log
grep -q "FAIL: see errors above" sim.log && { echo "simulation failed"; exit 1; }
grep -q "PASS: all tests" sim.log || { echo "simulation ended early"; exit 1; }
echo "simulation ok"
exit 0
